/* design/cache_ctrl_regs.sv */
// Cache control and status.
// Flush sequencer over all lines plus access and refill counters.
`default_nettype none

module cache_ctrl_regs import cache_pkg::*; #(
  parameter int STAT_W = 16
) (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          flush,
  input  wire logic          idle,
  input  wire logic          done,
  input  wire logic          fill_done,
  output inval_t             inval,
  output logic               block,
  output logic               flush_busy,
  output logic [STAT_W-1:0]  access_count,
  output logic [STAT_W-1:0]  fill_count
);

  logic               flush_pending;  // Pulse seen, waiting for the lookup to drain.
  logic               flushing;
  logic [INDEX_W-1:0] flush_index;
  logic               flush_start;
  logic               last_index;

  assign flush_start = flush_pending && !flushing && idle;
  assign last_index  = (flush_index == INDEX_W'(NUM_LINES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      flush_pending <= 1'b0;
      flushing      <= 1'b0;
      flush_index   <= '0;
    end else begin
      if (flush) begin
        flush_pending <= 1'b1;
      end else if (flush_start) begin
        flush_pending <= 1'b0;
      end

      if (flushing) begin
        flush_index <= flush_index + 1'b1;
        if (last_index) begin
          flushing <= 1'b0;
        end
      end else if (flush_start) begin
        flushing    <= 1'b1;
        flush_index <= '0;
      end
    end
  end

  // One line is cleared per cycle while the flush runs.
  assign inval.valid = flushing;
  assign inval.index = flush_index;

  // New requests are held off as soon as a flush is pending, so the slot drains.
  assign block      = flush_pending || flushing;
  assign flush_busy = flush_pending || flushing;

  // Both counters wrap.
  always_ff @(posedge clk) begin
    if (rst) begin
      access_count <= '0;
      fill_count   <= '0;
    end else begin
      if (done) begin
        access_count <= access_count + 1'b1;
      end
      if (fill_done) begin
        fill_count <= fill_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/cache_lookup.sv */
// Cache lookup.
// Tag, valid and data arrays with a one-stage read register, hit test and byte select.
`default_nettype none

module cache_lookup import cache_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                req_valid,
  input  wire cache_addr_t         req_addr,
  output logic                     req_ready,
  output logic                     rsp_valid,
  output logic [7:0]               rsp_data,
  input  wire logic                rsp_ready,
  input  wire fill_t               fill,
  input  wire inval_t              inval,
  input  wire logic                block,
  output logic                     miss,
  output logic [TAG_W-1:0]         miss_tag,
  output logic [INDEX_W-1:0]       miss_index,
  output logic                     idle,
  output logic                     done
);

  // Line storage with one entry per index.
  logic [NUM_LINES-1:0] valid_bits;
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [31:0]          data_mem [NUM_LINES];

  // The held request and the line that was read for it.
  logic                 held_valid;
  cache_addr_t          held_q;
  logic                 line_valid_q;
  logic [TAG_W-1:0]     line_tag_q;
  logic [31:0]          line_data_q;

  logic                 hit;
  logic                 fill_hit;

  assign hit      = line_valid_q && (line_tag_q == held_q.tag);
  assign fill_hit = fill.valid && (fill.index == held_q.index);  // Refill for the held miss.

  // A new request may enter when the result path is free and the slot empties.
  assign req_ready = rsp_ready && !block && (!held_valid || hit);

  assign rsp_valid = held_valid && hit;
  assign done      = rsp_valid && rsp_ready;
  assign miss      = held_valid && !hit;
  assign idle      = !held_valid;

  assign miss_tag   = held_q.tag;
  assign miss_index = held_q.index;

  // Offset 0 is the most significant byte of the word.
  always_comb begin
    case (held_q.offset)
      2'd0:    rsp_data = line_data_q[31:24];
      2'd1:    rsp_data = line_data_q[23:16];
      2'd2:    rsp_data = line_data_q[15:8];
      default: rsp_data = line_data_q[7:0];
    endcase
  end

  // Valid bits. A fill sets one line, the flush sequencer clears one line.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
    end else begin
      if (fill.valid) begin
        valid_bits[fill.index] <= 1'b1;
      end
      if (inval.valid) begin
        valid_bits[inval.index] <= 1'b0;
      end
    end
  end

  // Tag and data arrays are written only by the refill.
  always_ff @(posedge clk) begin
    if (fill.valid) begin
      tag_mem[fill.index]  <= fill.tag;
      data_mem[fill.index] <= fill.data;
    end
  end

  // Slot occupancy and the read valid bit.
  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid   <= 1'b0;
      line_valid_q <= 1'b0;
    end else if (req_ready) begin
      held_valid   <= req_valid;
      line_valid_q <= valid_bits[req_addr.index];
    end else begin
      // While blocked the slot still drains through the result port.
      if (done) begin
        held_valid <= 1'b0;
      end
      if (fill_hit) begin
        line_valid_q <= 1'b1;  // Held request now hits.
      end
    end
  end

  // Request fields and line payload are captured together on acceptance.
  always_ff @(posedge clk) begin
    if (req_ready) begin
      held_q      <= req_addr;
      line_tag_q  <= tag_mem[req_addr.index];
      line_data_q <= data_mem[req_addr.index];
    end else if (fill_hit) begin
      // The refilled word bypasses the array read.
      line_tag_q  <= fill.tag;
      line_data_q <= fill.data;
    end
  end

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
// Cache package.
// Address split, line write and invalidate records, refill FSM states.
`default_nettype none

package cache_pkg;

  // Widths of the fixed 16-bit address fields.
  localparam int TAG_W     = 8;
  localparam int INDEX_W   = 6;
  localparam int OFFSET_W  = 2;
  localparam int NUM_LINES = 64;  // One line per index value.

  // Request address as the lookup splits it, 16 bits in all.
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } cache_addr_t;

  // One line write from the refill FSM into the arrays.
  typedef struct packed {
    logic               valid;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic [31:0]        data;
  } fill_t;

  // One line invalidation from the flush sequencer.
  typedef struct packed {
    logic               valid;
    logic [INDEX_W-1:0] index;
  } inval_t;

  typedef enum logic [1:0] {
    RF_IDLE,   // Waiting for a miss.
    RF_FETCH,  // Strobe held high until the memory acknowledges.
    RF_WRITE   // Returned word goes into the line.
  } refill_state_t;

endpackage

`default_nettype wire

/* design/cache_refill.sv */
// Cache refill.
// Fetches the missing word from backing memory and writes it into the line.
`default_nettype none

module cache_refill import cache_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  miss,
  input  wire logic [TAG_W-1:0]      miss_tag,
  input  wire logic [INDEX_W-1:0]    miss_index,
  output logic                       mem_stb,
  output logic [TAG_W+INDEX_W-1:0]   mem_addr,
  input  wire logic [31:0]           mem_data,
  input  wire logic                  mem_ack,
  output fill_t                      fill,
  output logic                       fill_done
);

  refill_state_t state_q;
  refill_state_t state_d;
  logic [31:0]   word_q;  // Word returned by the memory.

  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE: begin
        if (miss) begin
          state_d = RF_FETCH;
        end
      end
      RF_FETCH: begin
        if (mem_ack) begin
          state_d = RF_WRITE;
        end
      end
      RF_WRITE: begin
        state_d = RF_IDLE;  // One write cycle, then the lookup hits.
      end
      default: begin
        state_d = RF_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The data is sampled on the acknowledge edge.
  always_ff @(posedge clk) begin
    if (state_q == RF_FETCH && mem_ack) begin
      word_q <= mem_data;
    end
  end

  // The lookup holds tag and index stable for the whole miss.
  assign mem_stb  = (state_q == RF_FETCH);
  assign mem_addr = {miss_tag, miss_index};  // Word address of the line.

  // In RF_WRITE the line is written and the held request is completed.
  always_comb begin
    fill.valid = (state_q == RF_WRITE);
    fill.index = miss_index;
    fill.tag   = miss_tag;
    fill.data  = word_q;
  end

  assign fill_done = (state_q == RF_WRITE);

endmodule

`default_nettype wire

/* design/cache_top.sv */
// Byte cache top level.
// Connects the lookup, refill and control blocks to the external ports.
`default_nettype none

module cache_top import cache_pkg::*; #(
  parameter int STAT_W = 16
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  // Request side.
  input  wire logic                  req_valid,
  input  wire cache_addr_t           req_addr,
  output logic                       req_ready,
  // Result side.
  output logic                       rsp_valid,
  output logic [7:0]                 rsp_data,
  input  wire logic                  rsp_ready,
  // Backing memory.
  output logic                       mem_stb,
  output logic [TAG_W+INDEX_W-1:0]   mem_addr,
  input  wire logic [31:0]           mem_data,
  input  wire logic                  mem_ack,
  // Control and status.
  input  wire logic                  flush,
  output logic                       flush_busy,
  output logic [STAT_W-1:0]          access_count,
  output logic [STAT_W-1:0]          fill_count
);

  logic               miss;
  logic [TAG_W-1:0]   miss_tag;
  logic [INDEX_W-1:0] miss_index;
  logic               idle;
  logic               done;
  logic               block;
  logic               fill_done;
  fill_t              fill;
  inval_t             inval;

  cache_lookup i_lookup (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_ready  (rsp_ready),
    .fill       (fill),
    .inval      (inval),
    .block      (block),
    .miss       (miss),
    .miss_tag   (miss_tag),
    .miss_index (miss_index),
    .idle       (idle),
    .done       (done)
  );

  cache_refill i_refill (
    .clk        (clk),
    .rst        (rst),
    .miss       (miss),
    .miss_tag   (miss_tag),
    .miss_index (miss_index),
    .mem_stb    (mem_stb),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .mem_ack    (mem_ack),
    .fill       (fill),
    .fill_done  (fill_done)
  );

  cache_ctrl_regs #(
    .STAT_W (STAT_W)
  ) i_ctrl_regs (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .idle         (idle),
    .done         (done),
    .fill_done    (fill_done),
    .inval        (inval),
    .block        (block),
    .flush_busy   (flush_busy),
    .access_count (access_count),
    .fill_count   (fill_count)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_cache -f sources.f -Mdir obj_dir -o tb_cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_cache_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

/* sim/tb_cache.sv */
// Byte cache testbench.
// Random requests with back-pressure against a reference tag model, plus a flush.
`default_nettype none

module tb_cache import cache_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RANDOM  = 400;
  localparam int N_CONFLICT = 40;
  localparam int N_TAIL    = 200;
  localparam int N_FLUSHES = 1;
  localparam int REQ_TOTAL = N_RANDOM + N_CONFLICT + NUM_LINES + N_TAIL;
  localparam int TIMEOUT_CYCLES = 40 * REQ_TOTAL + 200 * N_FLUSHES + 50;

  logic clk, rst, req_valid, req_ready, rsp_valid, rsp_ready;
  logic mem_stb, mem_ack, flush, flush_busy;
  cache_addr_t req_addr;
  logic [7:0] rsp_data;
  logic [TAG_W+INDEX_W-1:0] mem_addr;
  logic [31:0] mem_data;
  logic [15:0] access_count, fill_count;

  // Reference model state.
  logic             model_valid [NUM_LINES];
  logic [TAG_W-1:0] model_tag   [NUM_LINES];
  logic [7:0]       expect_q [$];   // Expected bytes in request order.
  cache_addr_t      replay_q [$];
  int errors, results, model_misses, model_hits, conflict_step, cycle_count;

  cache_top #(.STAT_W(16)) i_dut (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
    .mem_stb(mem_stb), .mem_addr(mem_addr), .mem_data(mem_data), .mem_ack(mem_ack),
    .flush(flush), .flush_busy(flush_busy), .access_count(access_count),
    .fill_count(fill_count)
  );

  tb_memory_model i_mem (
    .clk(clk), .rst(rst), .stb(mem_stb), .addr(mem_addr), .data(mem_data), .ack(mem_ack)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
    end
  endtask

  // Memory word for word address w with offset 0 in the most significant byte.
  function automatic logic [31:0] expected_word(input logic [13:0] w);
    logic [7:0] low_byte;
    low_byte = w[13:6] + w[7:0];
    return {w[13:6], w[5:0], 2'b10, w[7:0] ^ 8'ha5, low_byte};
  endfunction

  function automatic logic [7:0] byte_at(input logic [31:0] word, input logic [1:0] offset);
    return word[8*(3-offset) +: 8];  // Offset 0 is bits 31:24.
  endfunction

  function automatic cache_addr_t next_addr(input int mode);
    cache_addr_t a;
    a.offset = 2'($urandom_range(3));
    if (mode == 1) begin
      a.tag   = conflict_step[0] ? 8'hc5 : 8'h3a;  // Two tags fight for one line.
      a.index = 6'h21;
      conflict_step++;
    end else if (mode == 2 && replay_q.size() != 0) begin
      a = replay_q.pop_front();
    end else begin
      a.tag   = 8'(8'h30 + $urandom_range(3));
      a.index = 6'($urandom_range(15));
    end
    return a;
  endfunction

  task automatic record_accept(input cache_addr_t a);
    if (model_valid[a.index] && model_tag[a.index] == a.tag) begin
      model_hits++;
    end else begin
      model_misses++;
      model_valid[a.index] = 1'b1;
      model_tag[a.index]   = a.tag;
    end
    expect_q.push_back(byte_at(expected_word({a.tag, a.index}), a.offset));
  endtask

  // Samples both handshakes on a clock edge and then drives a new rsp_ready.
  task automatic clock_step(output logic accepted);
    @(posedge clk);
    accepted = 1'b0;
    if (rsp_valid && rsp_ready) begin
      results++;
      if (expect_q.size() == 0) begin
        errors++;
        $display("A result arrived at %0d ns with no request outstanding", $time);
      end else begin
        check_equal("rsp_data", 32'(rsp_data), 32'(expect_q.pop_front()));
      end
    end
    if (req_valid && req_ready) begin
      record_accept(req_addr);
      accepted = 1'b1;
    end
    rsp_ready <= ($urandom_range(9) < 7);
  endtask

  task automatic run_requests(input int n, input int mode);
    int sent;
    int made;
    logic accepted;
    sent = 0;
    made = 0;
    while (sent < n) begin
      clock_step(accepted);
      if (accepted) begin
        sent++;
      end
      if ((accepted || !req_valid) && made < n) begin
        req_valid <= 1'b1;
        req_addr  <= next_addr(mode);
        made++;
      end else if (accepted) begin
        req_valid <= 1'b0;
      end
    end
  endtask

  task automatic drain_and_check();
    logic accepted;
    while (expect_q.size() != 0) begin
      clock_step(accepted);
    end
    clock_step(accepted);  // The counters update on the last transfer edge.
    check_equal("access_count", 32'(access_count), results);
    check_equal("fill_count", 32'(fill_count), model_misses);
  endtask

  task automatic run_flush();
    logic accepted;
    int   wait_cycles;
    cache_addr_t a;
    for (int i = 0; i < NUM_LINES; i++) begin
      if (model_valid[i]) begin
        a.tag    = model_tag[i];
        a.index  = 6'(i);
        a.offset = 2'($urandom_range(3));
        replay_q.push_back(a);
      end
    end
    clock_step(accepted);
    flush <= 1'b1;
    clock_step(accepted);
    flush <= 1'b0;
    wait_cycles = 0;
    while (!flush_busy && wait_cycles < 4) begin
      clock_step(accepted);
      wait_cycles++;
    end
    if (!flush_busy) begin
      errors++;
      $display("flush_busy did not rise after the flush pulse");
    end
    while (flush_busy) begin
      clock_step(accepted);
    end
    for (int i = 0; i < NUM_LINES; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  initial begin
    logic [31:0] fills_before;
    int          replay_count;
    void'($urandom(32'h873));
    clk = 1'b0;
    rst = 1'b1;
    req_valid = 1'b0;
    req_addr = '0;
    rsp_ready = 1'b1;
    flush = 1'b0;
    errors = 0;
    results = 0;
    model_misses = 0;
    model_hits = 0;
    conflict_step = 0;
    cycle_count = 0;
    for (int i = 0; i < NUM_LINES; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_equal("mem_stb after reset", 32'(mem_stb), 0);
    check_equal("rsp_valid after reset", 32'(rsp_valid), 0);
    check_equal("flush_busy after reset", 32'(flush_busy), 0);
    check_equal("req_ready after reset", 32'(req_ready), 32'(rsp_ready));
    check_equal("access_count after reset", 32'(access_count), 0);
    check_equal("fill_count after reset", 32'(fill_count), 0);

    run_requests(N_RANDOM, 0);
    drain_and_check();

    fills_before = 32'(fill_count);
    run_requests(N_CONFLICT, 1);
    drain_and_check();
    check_equal("refills on a conflicting line", 32'(fill_count) - fills_before, N_CONFLICT);

    run_flush();
    replay_count = replay_q.size();
    fills_before = 32'(fill_count);
    run_requests(replay_count, 2);
    drain_and_check();
    check_equal("refills after flush", 32'(fill_count) - fills_before, replay_count);

    run_requests(N_TAIL, 0);
    drain_and_check();

    $display("Run complete: %0d errors, %0d results, %0d misses, %0d hits",
             errors, results, model_misses, model_hits);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_memory_model.sv */
// Backing memory model.
// Answers each strobe after a random wait with a word computed from its address.
`default_nettype none

module tb_memory_model import cache_pkg::*; (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      stb,
  input  wire logic [TAG_W+INDEX_W-1:0]  addr,
  output logic [31:0]                    data = '0,
  output logic                           ack = 1'b0
);
  timeunit 1ns;
  timeprecision 1ps;

  logic waiting;
  int   wait_count;

  // Every byte of the word depends on the word address.
  function automatic logic [31:0] word_pattern(input logic [TAG_W+INDEX_W-1:0] w);
    return {w, 2'b10, w[7:0] ^ 8'ha5, w[13:6] + w[7:0]};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      ack        <= 1'b0;
      data       <= '0;
      waiting    <= 1'b0;
      wait_count <= 0;
    end else if (ack) begin
      ack <= 1'b0;  // The strobe drops on the ack edge.
    end else if (stb) begin
      if (!waiting) begin
        waiting    <= 1'b1;
        wait_count <= $urandom_range(5);
      end else if (wait_count == 0) begin
        ack     <= 1'b1;
        data    <= word_pattern(addr);
        waiting <= 1'b0;
      end else begin
        wait_count <= wait_count - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* sources.f */
design/cache_pkg.sv
design/cache_lookup.sv
design/cache_refill.sv
design/cache_ctrl_regs.sv
design/cache_top.sv
sim/tb_memory_model.sv
sim/tb_cache.sv
